//--- mem_fabric_settings.svh
`ifndef MEM_FABRIC_SETTINGS_SVH
`define MEM_FABRIC_SETTINGS_SVH

// --------------------
// bus widths
// --------------------
`define MF_ADDR_W 32
`define MF_DATA_W 32
`define MF_STRB_W 4

// request queue entries, also the arbiter's starting credit
`define MF_REQ_QUEUE_DEPTH 4

// --------------------
// address map
// --------------------
`define MF_SRAM_BASE 32'h8000_0000
`define MF_SRAM_WORDS 256
`define MF_CLINT_BASE 32'h0200_0000
`define MF_MTIME_LO_OFS 32'h0000_BFF8
`define MF_MTIME_HI_OFS 32'h0000_BFFC

`endif

//--- mem_fabric_pkg.sv
`include "mem_fabric_settings.svh"

package mem_fabric_pkg;

	// --------------------
	// enums
	// --------------------
	typedef enum logic {
		SRC_FETCH = 1'b0,
		SRC_LSU   = 1'b1
	} req_src_e;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// same width as the axi resp field
	typedef enum logic [1:0] {
		RESP_OKAY  = 2'b00,
		RESP_FAULT = 2'b11
	} bus_resp_e;

	// --------------------
	// structs
	// --------------------
	// request as it travels arbiter -> queue -> crossbar
	typedef struct packed {
		logic [`MF_ADDR_W-1:0] addr;
		logic [`MF_DATA_W-1:0] wdata;
		logic [`MF_STRB_W-1:0] wstrb;
		bus_op_e               op;
		req_src_e              src;
	} bus_req_t;

	// load/store port payload, source is implied by the port
	typedef struct packed {
		logic [`MF_ADDR_W-1:0] addr;
		logic [`MF_DATA_W-1:0] wdata;
		logic [`MF_STRB_W-1:0] wstrb;
		bus_op_e               op;
	} lsu_req_t;

	typedef struct packed {
		logic [`MF_DATA_W-1:0] rdata;
		bus_resp_e             resp;
		req_src_e              src;
	} bus_rsp_t;

endpackage

//--- sram_store.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module sram_store (
	input  logic                             clock,
	input  logic                             we_i,
	input  logic [$clog2(`MF_SRAM_WORDS)-1:0] waddr_i,
	input  logic [$clog2(`MF_SRAM_WORDS)-1:0] raddr_i,
	input  logic [`MF_DATA_W-1:0]            wdata_i,
	input  logic [`MF_STRB_W-1:0]            wstrb_i,
	output logic [`MF_DATA_W-1:0]            rdata_o
);

	localparam int BYTE_W = `MF_DATA_W / `MF_STRB_W;

	logic [`MF_DATA_W-1:0] mem [`MF_SRAM_WORDS];

	// --------------------
	// write port
	// --------------------
	// only the strobed byte lanes change
	always_ff @(posedge clock) begin
		if (we_i) begin
			for (int i = 0; i < `MF_STRB_W; i++) begin
				if (wstrb_i[i]) begin
					mem[waddr_i][i*BYTE_W +: BYTE_W] <= wdata_i[i*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// --------------------
	// read port
	// --------------------
	// old data on a same-address write
	always_ff @(posedge clock) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

//--- clint_timer.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module clint_timer (
	input  logic                  clock,
	input  logic                  reset_i,
	input  logic                  hi_sel_i,
	output logic [`MF_DATA_W-1:0] rdata_o
);

	logic [63:0] mtime;

	// free running, one tick per clock
	always_ff @(posedge clock) begin
		if (reset_i) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// halves map to mtime and mtimeh
	assign rdata_o = hi_sel_i ? mtime[63:32] : mtime[31:0];

endmodule

//--- req_arbiter.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module req_arbiter (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     if_req_valid_i,
	input  logic [`MF_ADDR_W-1:0]    if_req_addr_i,
	output logic                     if_req_ready_o,
	input  logic                     lsu_req_valid_i,
	input  mem_fabric_pkg::lsu_req_t lsu_req_i,
	output logic                     lsu_req_ready_o,
	input  logic                     credit_i,
	output logic                     push_o,
	output mem_fabric_pkg::bus_req_t push_data_o
);
	import mem_fabric_pkg::*;

	localparam int DEPTH = `MF_REQ_QUEUE_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic             arb_en;
	logic             can_push;

	// held low for the first cycle out of reset
	assign can_push = arb_en && (credit_cnt != '0);

	// --------------------
	// fixed priority grant
	// --------------------
	// load/store wins, fetch only gets the slot when lsu is idle
	assign lsu_req_ready_o = can_push;
	assign if_req_ready_o  = can_push && !lsu_req_valid_i;
	assign push_o          = can_push && (lsu_req_valid_i || if_req_valid_i);

	always_comb begin
		if (lsu_req_valid_i) begin
			push_data_o.addr  = lsu_req_i.addr;
			push_data_o.wdata = lsu_req_i.wdata;
			push_data_o.wstrb = lsu_req_i.wstrb;
			push_data_o.op    = lsu_req_i.op;
			push_data_o.src   = SRC_LSU;
		end else begin
			// fetch is always a plain word read
			push_data_o.addr  = if_req_addr_i;
			push_data_o.wdata = '0;
			push_data_o.wstrb = '0;
			push_data_o.op    = OP_READ;
			push_data_o.src   = SRC_FETCH;
		end
	end

	// --------------------
	// credit counter
	// --------------------
	// one credit per free queue entry
	always_ff @(posedge clock) begin
		if (reset_i) begin
			credit_cnt <= CNT_W'(DEPTH);
			arb_en     <= 1'b0;
		end else begin
			arb_en <= 1'b1;
			case ({push_o, credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

//--- req_queue.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module req_queue (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     push_i,
	input  mem_fabric_pkg::bus_req_t push_data_i,
	output logic                     head_valid_o,
	output mem_fabric_pkg::bus_req_t head_o,
	input  logic                     pop_i,
	output logic                     credit_o
);
	import mem_fabric_pkg::*;

	localparam int DEPTH = `MF_REQ_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	bus_req_t         entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign head_valid_o = (count != '0);
	assign head_o       = entries[rd_ptr];
	assign do_pop       = pop_i && head_valid_o;

	// --------------------
	// storage
	// --------------------
	// no full check, the arbiter never pushes without a credit
	always_ff @(posedge clock) begin
		if (push_i) begin
			entries[wr_ptr] <= push_data_i;
		end
	end

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge clock) begin
		if (reset_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push_i, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// freed slot goes back to the arbiter
			credit_o <= do_pop;
		end
	end

endmodule

//--- addr_xbar.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module addr_xbar (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     head_valid_i,
	input  mem_fabric_pkg::bus_req_t head_i,
	output logic                     pop_o,
	output logic                     rsp_valid_o,
	output mem_fabric_pkg::bus_rsp_t rsp_o,
	input  logic                     rsp_ready_i
);
	import mem_fabric_pkg::*;

	localparam int IDX_W = $clog2(`MF_SRAM_WORDS);
	localparam logic [`MF_ADDR_W-1:0] SRAM_BYTES = `MF_SRAM_WORDS * 4;
	localparam logic [`MF_ADDR_W-1:0] MTIME_LO_ADDR = `MF_CLINT_BASE + `MF_MTIME_LO_OFS;
	localparam logic [`MF_ADDR_W-1:0] MTIME_HI_ADDR = `MF_CLINT_BASE + `MF_MTIME_HI_OFS;

	typedef enum logic [1:0] {
		TGT_SRAM,
		TGT_MTIME_LO,
		TGT_MTIME_HI,
		TGT_FAULT
	} target_e;

	target_e               target;
	logic [`MF_ADDR_W-1:0] sram_ofs;
	logic [IDX_W-1:0]      head_idx;
	logic [IDX_W-1:0]      held_idx;
	logic                  sram_we;
	logic [`MF_DATA_W-1:0] sram_rdata;
	logic [`MF_DATA_W-1:0] mtime_half;
	logic                  rsp_valid_q;
	logic                  sram_rd_q;
	bus_rsp_t              rsp_q;

	// --------------------
	// address decode
	// --------------------
	assign sram_ofs = head_i.addr - `MF_SRAM_BASE;
	assign head_idx = sram_ofs[IDX_W+1:2];

	// timer is read only, a write there faults
	always_comb begin
		if (sram_ofs < SRAM_BYTES) begin
			target = TGT_SRAM;
		end else if (head_i.op == OP_READ && head_i.addr == MTIME_LO_ADDR) begin
			target = TGT_MTIME_LO;
		end else if (head_i.op == OP_READ && head_i.addr == MTIME_HI_ADDR) begin
			target = TGT_MTIME_HI;
		end else begin
			target = TGT_FAULT;
		end
	end

	// take the head when the response slot is free or draining
	assign pop_o   = head_valid_i && (!rsp_valid_q || rsp_ready_i);
	assign sram_we = pop_o && (target == TGT_SRAM) && (head_i.op == OP_WRITE);

	// --------------------
	// devices
	// --------------------
	// read address parks on the held entry so sram data stays put
	sram_store sram_store_inst (
		.clock   (clock),
		.we_i    (sram_we),
		.waddr_i (head_idx),
		.raddr_i (pop_o ? head_idx : held_idx),
		.wdata_i (head_i.wdata),
		.wstrb_i (head_i.wstrb),
		.rdata_o (sram_rdata)
	);

	clint_timer clint_timer_inst (
		.clock    (clock),
		.reset_i  (reset_i),
		.hi_sel_i (target == TGT_MTIME_HI),
		.rdata_o  (mtime_half)
	);

	// --------------------
	// response register
	// --------------------
	always_ff @(posedge clock) begin
		if (reset_i) begin
			rsp_valid_q <= 1'b0;
		end else if (pop_o) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	// timer value is sampled here, sram data arrives from its own register
	always_ff @(posedge clock) begin
		if (pop_o) begin
			held_idx   <= head_idx;
			sram_rd_q  <= (target == TGT_SRAM) && (head_i.op == OP_READ);
			rsp_q.src  <= head_i.src;
			rsp_q.resp <= (target == TGT_FAULT) ? RESP_FAULT : RESP_OKAY;
			if (target == TGT_MTIME_LO || target == TGT_MTIME_HI) begin
				rsp_q.rdata <= mtime_half;
			end else begin
				rsp_q.rdata <= '0;
			end
		end
	end

	always_comb begin
		rsp_o = rsp_q;
		if (sram_rd_q) begin
			rsp_o.rdata = sram_rdata;
		end
	end

	assign rsp_valid_o = rsp_valid_q;

endmodule

//--- mem_fabric_top.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module mem_fabric_top (
	input  logic                     clock,
	input  logic                     reset_i,
	// fetch request
	input  logic                     if_req_valid_i,
	input  logic [`MF_ADDR_W-1:0]    if_req_addr_i,
	output logic                     if_req_ready_o,
	// load/store request
	input  logic                     lsu_req_valid_i,
	input  mem_fabric_pkg::lsu_req_t lsu_req_i,
	output logic                     lsu_req_ready_o,
	// responses, one payload shared by both ports
	output logic                     if_rsp_valid_o,
	output logic                     lsu_rsp_valid_o,
	output mem_fabric_pkg::bus_rsp_t rsp_o,
	input  logic                     if_rsp_ready_i,
	input  logic                     lsu_rsp_ready_i
);
	import mem_fabric_pkg::*;

	logic     push;
	bus_req_t push_data;
	logic     credit;
	logic     head_valid;
	bus_req_t head;
	logic     pop;
	logic     rsp_valid;
	logic     rsp_ready;

	req_arbiter req_arbiter_inst (
		.clock           (clock),
		.reset_i         (reset_i),
		.if_req_valid_i  (if_req_valid_i),
		.if_req_addr_i   (if_req_addr_i),
		.if_req_ready_o  (if_req_ready_o),
		.lsu_req_valid_i (lsu_req_valid_i),
		.lsu_req_i       (lsu_req_i),
		.lsu_req_ready_o (lsu_req_ready_o),
		.credit_i        (credit),
		.push_o          (push),
		.push_data_o     (push_data)
	);

	req_queue req_queue_inst (
		.clock        (clock),
		.reset_i      (reset_i),
		.push_i       (push),
		.push_data_i  (push_data),
		.head_valid_o (head_valid),
		.head_o       (head),
		.pop_i        (pop),
		.credit_o     (credit)
	);

	addr_xbar addr_xbar_inst (
		.clock        (clock),
		.reset_i      (reset_i),
		.head_valid_i (head_valid),
		.head_i       (head),
		.pop_o        (pop),
		.rsp_valid_o  (rsp_valid),
		.rsp_o        (rsp_o),
		.rsp_ready_i  (rsp_ready)
	);

	// --------------------
	// response steering
	// --------------------
	// src tag picks which port sees valid and whose ready counts
	assign if_rsp_valid_o  = rsp_valid && (rsp_o.src == SRC_FETCH);
	assign lsu_rsp_valid_o = rsp_valid && (rsp_o.src == SRC_LSU);
	assign rsp_ready       = (rsp_o.src == SRC_FETCH) ? if_rsp_ready_i : lsu_rsp_ready_i;

endmodule

//--- mem_fabric_assertions.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module mem_fabric_assertions (
	input logic                                     clock,
	input logic                                     reset_i,
	input logic                                     push_i,
	input logic [$clog2(`MF_REQ_QUEUE_DEPTH+1)-1:0] credit_cnt_i,
	input logic [$clog2(`MF_REQ_QUEUE_DEPTH+1)-1:0] queue_count_i,
	input logic                                     rsp_valid_i,
	input logic                                     rsp_ready_i,
	input mem_fabric_pkg::bus_rsp_t                 rsp_i
);

	// read by the testbench top at the end of the run
	int fail_count = 0;

	// --------------------
	// credit rules
	// --------------------
	// credits must keep the queue from overflowing
	push_has_room: assert property (@(posedge clock) disable iff (reset_i)
		push_i |-> (queue_count_i < `MF_REQ_QUEUE_DEPTH))
		else begin
			fail_count++;
			$error("push into a full request queue");
		end

	credit_in_range: assert property (@(posedge clock) disable iff (reset_i)
		credit_cnt_i <= `MF_REQ_QUEUE_DEPTH)
		else begin
			fail_count++;
			$error("credit count above the queue depth");
		end

	// --------------------
	// response handshake
	// --------------------
	// a stalled response keeps its valid and payload
	rsp_held: assert property (@(posedge clock) disable iff (reset_i)
		(rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
		else begin
			fail_count++;
			$error("response changed or dropped while not accepted");
		end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clock_o,
	output logic reset_o
);

	initial begin
		clock_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock_o = ~clock_o;
		end
	end

	// reset spans the first few rising edges, released just after one
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1;
		reset_o = 1'b0;
	end

endmodule

//--- tb_mem_fabric.sv
`timescale 1ns/1ps
`include "mem_fabric_settings.svh"

module tb_mem_fabric;
	import mem_fabric_pkg::*;

	localparam int DEPTH        = `MF_REQ_QUEUE_DEPTH;
	localparam int TIMEOUT      = 200;
	localparam int STALL_CYCLES = 10;
	localparam int MAX_VEC      = 64;
	localparam logic [31:0] MTIME_LO_ADDR = `MF_CLINT_BASE + `MF_MTIME_LO_OFS;

	logic                  clock;
	logic                  reset;
	logic                  if_req_valid;
	logic [`MF_ADDR_W-1:0] if_req_addr;
	logic                  if_req_ready;
	logic                  lsu_req_valid;
	lsu_req_t              lsu_req;
	logic                  lsu_req_ready;
	logic                  if_rsp_valid;
	logic                  lsu_rsp_valid;
	bus_rsp_t              rsp;
	logic                  if_rsp_ready;
	logic                  lsu_rsp_ready;

	// vectors from tb_input.txt
	int          v_test  [MAX_VEC];
	bit          v_port  [MAX_VEC];
	bit          v_op    [MAX_VEC];
	logic [31:0] v_addr  [MAX_VEC];
	logic [31:0] v_wdata [MAX_VEC];
	logic [3:0]  v_strb  [MAX_VEC];
	logic [31:0] v_rdata [MAX_VEC];
	logic [1:0]  v_resp  [MAX_VEC];
	int          num_vec;

	// accepted requests in grant order, and responses as they arrive
	int          exp_idx   [$];
	bit          got_port  [$];
	logic [31:0] got_rdata [$];
	logic [1:0]  got_resp  [$];

	// 0 both readys high, 1 both low, 2 random
	int          ready_mode = 0;
	integer      seed = 87;
	int          test_checks = 0;
	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [31:0] last_mtime_lo;
	bit          have_mtime_lo = 1'b0;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) tb_clock_gen_inst (
		.clock_o (clock),
		.reset_o (reset)
	);

	mem_fabric_top mem_fabric_top_inst (
		.clock           (clock),
		.reset_i         (reset),
		.if_req_valid_i  (if_req_valid),
		.if_req_addr_i   (if_req_addr),
		.if_req_ready_o  (if_req_ready),
		.lsu_req_valid_i (lsu_req_valid),
		.lsu_req_i       (lsu_req),
		.lsu_req_ready_o (lsu_req_ready),
		.if_rsp_valid_o  (if_rsp_valid),
		.lsu_rsp_valid_o (lsu_rsp_valid),
		.rsp_o           (rsp),
		.if_rsp_ready_i  (if_rsp_ready),
		.lsu_rsp_ready_i (lsu_rsp_ready)
	);

	bind mem_fabric_top mem_fabric_assertions mem_fabric_assertions_inst (
		.clock         (clock),
		.reset_i       (reset_i),
		.push_i        (push),
		.credit_cnt_i  (req_arbiter_inst.credit_cnt),
		.queue_count_i (req_queue_inst.count),
		.rsp_valid_i   (rsp_valid),
		.rsp_ready_i   (rsp_ready),
		.rsp_i         (rsp_o)
	);

	// --------------------
	// response side
	// --------------------
	initial begin
		logic [31:0] rnd;
		if_rsp_ready  = 1'b1;
		lsu_rsp_ready = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			rnd = $random(seed);
			if_rsp_ready  = (ready_mode == 0) || (ready_mode == 2 && rnd[0]);
			lsu_rsp_ready = (ready_mode == 0) || (ready_mode == 2 && rnd[1]);
		end
	end

	// a response moves at the next rising edge when valid and ready
	always @(negedge clock) begin
		if (!reset && if_rsp_valid && if_rsp_ready) begin
			got_port.push_back(1'b0);
			got_rdata.push_back(rsp.rdata);
			got_resp.push_back(rsp.resp);
		end
		if (!reset && lsu_rsp_valid && lsu_rsp_ready) begin
			got_port.push_back(1'b1);
			got_rdata.push_back(rsp.rdata);
			got_resp.push_back(rsp.resp);
		end
	end

	// --------------------
	// helpers
	// --------------------
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic load_vectors();
		int             fd;
		int             n;
		int             t;
		int             p;
		int             o;
		logic [31:0]    a;
		logic [31:0]    w;
		logic [3:0]     s;
		logic [31:0]    rd;
		logic [1:0]     rs;
		reg [8*160-1:0] line;
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0) begin
			abort_run("could not open tb_input.txt");
		end else begin
			num_vec = 0;
			while (!$feof(fd)) begin
				line = '0;
				n = $fgets(line, fd);
				// comment and blank lines do not scan as eight fields
				n = $sscanf(line, "%d %d %d %h %h %h %h %h", t, p, o, a, w, s, rd, rs);
				if (n == 8 && num_vec < MAX_VEC) begin
					v_test[num_vec]  = t;
					v_port[num_vec]  = p[0];
					v_op[num_vec]    = o[0];
					v_addr[num_vec]  = a;
					v_wdata[num_vec] = w;
					v_strb[num_vec]  = s;
					v_rdata[num_vec] = rd;
					v_resp[num_vec]  = rs;
					num_vec++;
				end
			end
			$fclose(fd);
		end
	endtask

	function automatic string test_name(input int num);
		case (num)
			1: return "sram write and read";
			2: return "fetch read";
			3: return "access faults";
			4: return "mtime reads";
			5: return "same-cycle priority";
			6: return "back-pressure";
			default: return "unnamed";
		endcase
	endfunction

	task automatic set_req(input int idx);
		if (v_port[idx]) begin
			lsu_req_valid = 1'b1;
			lsu_req.addr  = v_addr[idx];
			lsu_req.wdata = v_wdata[idx];
			lsu_req.wstrb = v_strb[idx];
			lsu_req.op    = bus_op_e'(v_op[idx]);
		end else begin
			if_req_valid = 1'b1;
			if_req_addr  = v_addr[idx];
		end
	endtask

	task automatic drive_req(input int idx);
		@(posedge clock);
		#1;
		set_req(idx);
	endtask

	// ready is sampled mid-cycle, the transfer is the following edge
	task automatic wait_accept(input int idx, input int limit, output bit ok);
		int waited;
		bit seen;
		ok = 1'b0;
		waited = 0;
		while (!ok && waited < limit) begin
			@(negedge clock);
			seen = v_port[idx] ? lsu_req_ready : if_req_ready;
			@(posedge clock);
			if (seen) begin
				ok = 1'b1;
			end else begin
				waited++;
			end
		end
		#1;
		if (ok) begin
			if (v_port[idx]) begin
				lsu_req_valid = 1'b0;
			end else begin
				if_req_valid = 1'b0;
			end
			exp_idx.push_back(idx);
		end
	endtask

	task automatic issue(input int idx);
		bit ok;
		drive_req(idx);
		wait_accept(idx, TIMEOUT, ok);
		if (!ok) begin
			abort_run($sformatf("timeout in test %0d: request to %h was never accepted",
				v_test[idx], v_addr[idx]));
		end
	endtask

	task automatic check_next();
		int waited;
		int idx;
		bit port;
		logic [31:0] rdata;
		logic [1:0] resp;
		waited = 0;
		while (got_port.size() == 0 && waited < TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (got_port.size() == 0) begin
			abort_run($sformatf("timeout in test %0d: no response arrived", v_test[exp_idx[0]]));
		end else begin
			idx = exp_idx.pop_front();
			port = got_port.pop_front();
			rdata = got_rdata.pop_front();
			resp = got_resp.pop_front();
			test_checks++;
			assert (port == v_port[idx]) else begin
				test_errors++;
				$display("FAIL %0t: test %0d response for %h came back on the wrong port",
					$time, v_test[idx], v_addr[idx]);
			end
			assert (resp == v_resp[idx]) else begin
				test_errors++;
				$display("FAIL %0t: test %0d resp %0d for %h, expected %0d",
					$time, v_test[idx], resp, v_addr[idx], v_resp[idx]);
			end
			// mtime low half has no fixed value, it only has to move forward
			if (v_addr[idx] == MTIME_LO_ADDR && v_op[idx] == 1'b0) begin
				if (have_mtime_lo) begin
					assert (rdata > last_mtime_lo) else begin
						test_errors++;
						$display("FAIL %0t: test %0d mtime %h not above previous %h",
							$time, v_test[idx], rdata, last_mtime_lo);
					end
				end
				last_mtime_lo = rdata;
				have_mtime_lo = 1'b1;
			end else begin
				assert (rdata === v_rdata[idx]) else begin
					test_errors++;
					$display("FAIL %0t: test %0d rdata %h for %h, expected %h",
						$time, v_test[idx], rdata, v_addr[idx], v_rdata[idx]);
				end
			end
		end
	endtask

	task automatic end_test(input int num);
		if (test_errors == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d %s: %0d checks, %0d errors", num, test_name(num), test_checks,
			test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int  waited;
		int  fetch_idx;
		int  lsu_idx;
		int  held;
		bit  ok;
		bit  stalled;
		int  assert_fails;
		if_req_valid  = 1'b0;
		if_req_addr   = '0;
		lsu_req_valid = 1'b0;
		lsu_req       = '0;
		load_vectors();

		waited = 0;
		while (reset && waited < TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (reset) begin
			abort_run("reset was never released");
		end

		// one request at a time
		for (int t = 1; t <= 4; t++) begin
			for (int i = 0; i < num_vec; i++) begin
				if (v_test[i] == t) begin
					issue(i);
					check_next();
				end
			end
			end_test(t);
		end

		// both ports in the same cycle, load/store must win
		fetch_idx = -1;
		lsu_idx = -1;
		for (int i = 0; i < num_vec; i++) begin
			if (v_test[i] == 5 && v_port[i]) begin
				lsu_idx = i;
			end else if (v_test[i] == 5) begin
				fetch_idx = i;
			end
		end
		if (fetch_idx < 0 || lsu_idx < 0) begin
			abort_run("tb_input.txt has no fetch and load/store pair for test 5");
		end
		@(posedge clock);
		#1;
		set_req(fetch_idx);
		set_req(lsu_idx);
		#2;
		test_checks++;
		assert (lsu_req_ready && !if_req_ready) else begin
			test_errors++;
			$display("FAIL %0t: test 5 grant went to fetch over load/store", $time);
		end
		wait_accept(lsu_idx, TIMEOUT, ok);
		if (!ok) begin
			abort_run("timeout in test 5: load/store request was never accepted");
		end
		wait_accept(fetch_idx, TIMEOUT, ok);
		if (!ok) begin
			abort_run("timeout in test 5: fetch request was never accepted");
		end
		check_next();
		check_next();
		end_test(5);

		// responses held back until the request side stalls
		ready_mode = 1;
		held = 0;
		stalled = 1'b0;
		for (int i = 0; i < num_vec; i++) begin
			if (v_test[i] == 6) begin
				drive_req(i);
				wait_accept(i, stalled ? TIMEOUT : STALL_CYCLES, ok);
				if (!ok && !stalled) begin
					stalled = 1'b1;
					test_checks++;
					// full queue plus the held response
					assert (held == DEPTH + 1) else begin
						test_errors++;
						$display("FAIL %0t: test 6 %0d transfers with responses blocked, expected %0d",
							$time, held, DEPTH + 1);
					end
					ready_mode = 2;
					wait_accept(i, TIMEOUT, ok);
				end
				if (!ok) begin
					abort_run("timeout in test 6: request was never accepted");
				end
				if (!stalled) begin
					held++;
				end
			end
		end
		test_checks++;
		assert (stalled) else begin
			test_errors++;
			$display("FAIL %0t: test 6 request ready never dropped", $time);
		end
		while (exp_idx.size() > 0) begin
			check_next();
		end
		ready_mode = 0;
		end_test(6);

		assert_fails = mem_fabric_top_inst.mem_fabric_assertions_inst.fail_count;
		$display("tests passed %0d, tests failed %0d, assertion failures %0d",
			tests_passed, tests_failed, assert_fails);
		if (tests_failed == 0 && assert_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tb_input.txt
# test port(0 fetch,1 lsu) op(0 rd,1 wr) addr wdata strb exp_rdata exp_resp(0 okay,3 fault)
# mtime low reads only need to increase, their exp_rdata is unused
1 1 1 80000000 11223344 f 00000000 0
1 1 1 80000004 a5a5a5a5 f 00000000 0
1 1 1 80000008 deadbeef f 00000000 0
1 1 1 80000000 000000ee 1 00000000 0
1 1 1 80000004 5a5a0000 c 00000000 0
1 1 1 80000008 0000cc00 2 00000000 0
1 1 0 80000000 00000000 0 112233ee 0
1 1 0 80000004 00000000 0 5a5aa5a5 0
1 1 0 80000008 00000000 0 deadccef 0
2 0 0 80000000 00000000 0 112233ee 0
2 0 0 80000008 00000000 0 deadccef 0
2 1 1 800003fc 0badf00d f 00000000 0
2 0 0 800003fc 00000000 0 0badf00d 0
3 1 0 80000400 00000000 0 00000000 3
3 0 0 10000000 00000000 0 00000000 3
3 1 1 0200bff8 12345678 f 00000000 3
4 1 0 0200bff8 00000000 0 00000000 0
4 1 0 0200bff8 00000000 0 00000000 0
4 1 0 0200bffc 00000000 0 00000000 0
5 0 0 80000004 00000000 0 5a5aa5a5 0
5 1 0 80000008 00000000 0 deadccef 0
6 1 0 80000000 00000000 0 112233ee 0
6 1 0 80000004 00000000 0 5a5aa5a5 0
6 1 0 80000008 00000000 0 deadccef 0
6 1 0 800003fc 00000000 0 0badf00d 0
6 1 0 80000000 00000000 0 112233ee 0
6 1 0 80000400 00000000 0 00000000 3

//--- list.f
+incdir+.
mem_fabric_pkg.sv
sram_store.sv
clint_timer.sv
req_arbiter.sv
req_queue.sv
addr_xbar.sv
mem_fabric_top.sv
mem_fabric_assertions.sv
tb_clock_gen.sv
tb_mem_fabric.sv

//--- Bender.yml
package:
  name: mem_fabric

export_include_dirs:
  - .

sources:
  - mem_fabric_pkg.sv
  - sram_store.sv
  - clint_timer.sv
  - req_arbiter.sv
  - req_queue.sv
  - addr_xbar.sv
  - mem_fabric_top.sv
  - target: test
    files:
      - mem_fabric_assertions.sv
      - tb_clock_gen.sv
      - tb_mem_fabric.sv
